// ==== project.f ====
common/periph_xbar_pkg.sv
periph_xbar/periph_req_stage.sv
periph_xbar/periph_rr_arbiter.sv
periph_xbar/periph_resp_router.sv
logic/cluster_periph_xbar.sv
verif/periph_xbar_checker.sv
verif/tb_periph_xbar.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the crossbar testbench with Verilator
cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing -f project.f --top-module tb_periph_xbar -Mdir "$BUILD_DIR"
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

"./$BUILD_DIR/Vtb_periph_xbar" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -qx "Simulation PASSED" "$LOG"; then
  exit 0
fi
exit 1

// ==== verif/tb_periph_xbar.sv ====
// Testbench for the peripheral crossbar with 4 masters and 4 slaves.
// Slave models keep a word memory keyed by address bits [9:2]; bits [9:8]
// carry the master index so masters never share a word.
// The last quarter sends all traffic to slave 1 with its grant held high.
`timescale 1ns/1ps
`default_nettype none

module tb_periph_xbar;

  import periph_xbar_pkg::*;

  localparam int NB_MASTERS     = 4;
  localparam int NB_SLAVES      = 4;
  localparam int TXN_PER_MASTER = 100;
  localparam int NUM_TXN        = NB_MASTERS * TXN_PER_MASTER;
  localparam int HOT_START      = TXN_PER_MASTER * 3 / 4;
  localparam int CLK_PERIOD     = 8;
  localparam int TIMEOUT_CYCLES = NUM_TXN * 40;
  localparam int MEM_WORDS      = 256;

  logic                                 clk_i;
  logic                                 reset_i = 1'b1;
  logic [NB_MASTERS-1:0]                m_req_i = '0;
  addr_t [NB_MASTERS-1:0]               m_add_i = '0;
  logic [NB_MASTERS-1:0]                m_wen_i = '0;
  data_t [NB_MASTERS-1:0]               m_wdata_i = '0;
  be_t [NB_MASTERS-1:0]                 m_be_i = '0;
  logic [NB_MASTERS-1:0]                m_gnt_o;
  logic [NB_MASTERS-1:0]                m_r_valid_o;
  data_t [NB_MASTERS-1:0]               m_r_rdata_o;
  logic [NB_SLAVES-1:0]                 s_req_o;
  addr_t [NB_SLAVES-1:0]                s_add_o;
  logic [NB_SLAVES-1:0]                 s_wen_o;
  data_t [NB_SLAVES-1:0]                s_wdata_o;
  be_t [NB_SLAVES-1:0]                  s_be_o;
  logic [NB_SLAVES-1:0][NB_MASTERS-1:0] s_id_o;
  logic [NB_SLAVES-1:0]                 s_gnt_i = '0;
  logic [NB_SLAVES-1:0]                 s_r_valid_i = '0;
  data_t [NB_SLAVES-1:0]                s_r_rdata_i = '0;
  logic [NB_SLAVES-1:0][NB_MASTERS-1:0] s_r_id_i = '0;

  logic [31:0]           lcg_state = 32'd28041;
  logic [NB_MASTERS-1:0] busy = '0;
  int                    issued [NB_MASTERS];
  int                    resp_count = 0;
  int                    chk_errors;
  int                    chk_responses;
  int                    total_issued;
  logic                  hot_phase;
  data_t                 mem [NB_SLAVES][MEM_WORDS];

  cluster_periph_xbar #(
    .NB_MASTERS (NB_MASTERS),
    .NB_SLAVES  (NB_SLAVES)
  ) cluster_periph_xbar_inst (
    .clk_i (clk_i), .reset_i (reset_i),
    .m_req_i (m_req_i), .m_add_i (m_add_i), .m_wen_i (m_wen_i),
    .m_wdata_i (m_wdata_i), .m_be_i (m_be_i), .m_gnt_o (m_gnt_o),
    .m_r_valid_o (m_r_valid_o), .m_r_rdata_o (m_r_rdata_o),
    .s_req_o (s_req_o), .s_add_o (s_add_o), .s_wen_o (s_wen_o),
    .s_wdata_o (s_wdata_o), .s_be_o (s_be_o), .s_id_o (s_id_o),
    .s_gnt_i (s_gnt_i), .s_r_valid_i (s_r_valid_i),
    .s_r_rdata_i (s_r_rdata_i), .s_r_id_i (s_r_id_i)
  );

  periph_xbar_checker #(
    .NB_MASTERS (NB_MASTERS),
    .NB_SLAVES  (NB_SLAVES)
  ) periph_xbar_checker_inst (
    .clk_i (clk_i), .reset_i (reset_i),
    .m_req_i (m_req_i), .m_add_i (m_add_i), .m_wen_i (m_wen_i),
    .m_wdata_i (m_wdata_i), .m_be_i (m_be_i), .m_gnt_i (m_gnt_o),
    .m_r_valid_i (m_r_valid_o), .m_r_rdata_i (m_r_rdata_o),
    .s_req_i (s_req_o), .s_add_i (s_add_o), .s_wen_i (s_wen_o),
    .s_wdata_i (s_wdata_o), .s_be_i (s_be_o), .s_id_i (s_id_o),
    .s_gnt_i (s_gnt_i), .errors_o (chk_errors), .checked_o (chk_responses)
  );

  assign hot_phase = (issued[0] >= HOT_START);

  // Low bits of the state are weak, so the high half is returned in the low half
  function automatic logic [31:0] rnd();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return {lcg_state[15:0], lcg_state[31:16]};
  endfunction

  function automatic addr_t make_addr(input int m, input int tgt, input logic [31:0] r);
    addr_t a;
    a = {8'h10, (r[0] ? 4'h3 : 4'h2), r[3:2], 2'(tgt), r[7:4], 4'(m), 4'h0, r[9:8], 2'b00};
    if (tgt == NB_SLAVES - 1 && r[11:10] != 2'd0) begin
      // Outside the window the routing bits must be ignored
      case (r[11:10])
        2'd1:    a[23:20] = r[12] ? 4'h1 : 4'h7;
        2'd2:    a[31:24] = 8'h1C;
        default: a[31:24] = 8'h40;
      endcase
      a[17:16] = r[14:13];
    end
    return a;
  endfunction

  initial begin
    clk_i = 1'b0;
    forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
  end

  always @(posedge clk_i) begin : stimulus
    logic [31:0] r;
    logic [31:0] ra;
    logic [31:0] rd;
    int          tgt;
    int          key;
    if (reset_i) begin
      m_req_i     <= '0;
      busy        <= '0;
      s_gnt_i     <= '0;
      s_r_valid_i <= '0;
      for (int m = 0; m < NB_MASTERS; m++) issued[m] <= 0;
      for (int s = 0; s < NB_SLAVES; s++) begin
        for (int w = 0; w < MEM_WORDS; w++) mem[s][w] = 32'hA500_0000 | (s << 16) | w;
      end
    end else begin
      for (int m = 0; m < NB_MASTERS; m++) begin
        r  = rnd();
        ra = rnd();
        rd = rnd();
        if (m_req_i[m] && m_gnt_o[m]) begin
          m_req_i[m] <= 1'b0;
        end else if (!busy[m] && issued[m] < TXN_PER_MASTER && r[1:0] != 2'd0) begin
          tgt = hot_phase ? 1 : int'(r[3:2]);
          m_req_i[m]   <= 1'b1;
          m_add_i[m]   <= make_addr(m, tgt, ra);
          m_wen_i[m]   <= r[4];
          m_wdata_i[m] <= rd;
          m_be_i[m]    <= r[8:5];
          busy[m]      <= 1'b1;
          issued[m]    <= issued[m] + 1;
        end
        if (m_r_valid_o[m]) busy[m] <= 1'b0;
      end
      resp_count <= resp_count + $countones(m_r_valid_o);

      // Slave models answer one cycle after each transfer
      for (int s = 0; s < NB_SLAVES; s++) begin
        r = rnd();
        s_gnt_i[s]     <= (hot_phase && s == 1) || (r[1:0] != 2'd0);
        s_r_valid_i[s] <= s_req_o[s] && s_gnt_i[s];
        if (s_req_o[s] && s_gnt_i[s]) begin
          key = int'(s_add_o[s][9:2]);
          s_r_id_i[s]    <= s_id_o[s];
          s_r_rdata_i[s] <= s_wen_o[s] ? mem[s][key] : '0;
          if (!s_wen_o[s]) begin
            for (int b = 0; b < BE_WIDTH; b++) begin
              if (s_be_o[s][b]) mem[s][key][8*b +: 8] = s_wdata_o[s][8*b +: 8];
            end
          end
        end
      end
    end
  end

  initial begin
    reset_i = 1'b1;
    repeat (3) @(posedge clk_i);
    reset_i <= 1'b0;
    while (resp_count < NUM_TXN) @(posedge clk_i);
    repeat (4) @(posedge clk_i);
    total_issued = 0;
    for (int m = 0; m < NB_MASTERS; m++) total_issued = total_issued + issued[m];
    $display("Requests %0d, responses checked %0d, errors %0d",
             total_issued, chk_responses, chk_errors);
    if (chk_errors == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

  initial begin : watchdog
    repeat (TIMEOUT_CYCLES + 10) @(posedge clk_i);
    $display("Timeout with %0d of %0d responses received", resp_count, NUM_TXN);
    $display("Simulation FAILED");
    $finish;
  end

endmodule

`default_nettype wire

// ==== verif/periph_xbar_checker.sv ====
// Watches the crossbar ports and compares them with a model of the crossbar.
// Slave memories are mirrored here and keyed by address bits [9:2].
// The fill value of an unwritten word must match the slave models.
`timescale 1ns/1ps
`default_nettype none

module periph_xbar_checker #(
  parameter int NB_MASTERS = 4,
  parameter int NB_SLAVES  = 4
) (
  input  wire logic                                     clk_i,
  input  wire logic                                     reset_i,
  input  wire logic [NB_MASTERS-1:0]                    m_req_i,
  input  wire periph_xbar_pkg::addr_t [NB_MASTERS-1:0]  m_add_i,
  input  wire logic [NB_MASTERS-1:0]                    m_wen_i,
  input  wire periph_xbar_pkg::data_t [NB_MASTERS-1:0]  m_wdata_i,
  input  wire periph_xbar_pkg::be_t [NB_MASTERS-1:0]    m_be_i,
  input  wire logic [NB_MASTERS-1:0]                    m_gnt_i,
  input  wire logic [NB_MASTERS-1:0]                    m_r_valid_i,
  input  wire periph_xbar_pkg::data_t [NB_MASTERS-1:0]  m_r_rdata_i,
  input  wire logic [NB_SLAVES-1:0]                     s_req_i,
  input  wire periph_xbar_pkg::addr_t [NB_SLAVES-1:0]   s_add_i,
  input  wire logic [NB_SLAVES-1:0]                     s_wen_i,
  input  wire periph_xbar_pkg::data_t [NB_SLAVES-1:0]   s_wdata_i,
  input  wire periph_xbar_pkg::be_t [NB_SLAVES-1:0]     s_be_i,
  input  wire logic [NB_SLAVES-1:0][NB_MASTERS-1:0]     s_id_i,
  input  wire logic [NB_SLAVES-1:0]                     s_gnt_i,
  output int                                            errors_o,
  output int                                            checked_o
);

  import periph_xbar_pkg::*;

  localparam int MEM_WORDS = 256;

  data_t                 mirror [NB_SLAVES][MEM_WORDS];
  logic [NB_MASTERS-1:0] pending = '0;
  logic [NB_MASTERS-1:0] forwarded = '0;
  addr_t                 exp_add [NB_MASTERS];
  data_t                 exp_wdata [NB_MASTERS];
  logic                  exp_wen [NB_MASTERS];
  be_t                   exp_be [NB_MASTERS];
  int                    exp_target [NB_MASTERS];
  data_t                 exp_rdata [NB_MASTERS];
  int                    waits [NB_MASTERS];
  logic                  reset_q = 1'b0;
  int                    err_count = 0;
  int                    resp_count = 0;

  assign errors_o  = err_count;
  assign checked_o = resp_count;

  // Routing field inside the cluster peripheral window, else the external slave
  function automatic int decode_target(input addr_t a);
    if (a[31:24] == 8'h10 && (a[23:20] == 4'h2 || a[23:20] == 4'h3)) begin
      return int'(a[31:16]) % NB_SLAVES;
    end
    return NB_SLAVES - 1;
  endfunction

  task automatic report_value(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
    $display("ERR %s got %h exp %h at %0t", name, got, exp, $time);
    err_count = err_count + 1;
  endtask

  task automatic report_problem(input string msg);
    $display("%s at %0t", msg, $time);
    err_count = err_count + 1;
  endtask

  always @(posedge clk_i) begin : watch
    int m;
    int key;
    reset_q <= reset_i;
    if (reset_i) begin
      if (reset_q) begin
        if (s_req_i !== '0) report_value("s_req_o", 32'(s_req_i), 32'h0);
        if (m_r_valid_i !== '0) report_value("m_r_valid_o", 32'(m_r_valid_i), 32'h0);
        if (m_gnt_i !== '1) report_value("m_gnt_o", 32'(m_gnt_i), 32'(2**NB_MASTERS - 1));
      end
      pending   = '0;
      forwarded = '0;
      for (int s = 0; s < NB_SLAVES; s++) begin
        for (int w = 0; w < MEM_WORDS; w++) begin
          mirror[s][w] = 32'hA500_0000 | (s << 16) | w;
        end
      end
    end else begin
      for (int i = 0; i < NB_MASTERS; i++) begin
        if (m_r_valid_i[i]) begin
          resp_count = resp_count + 1;
          if (!pending[i] || !forwarded[i]) begin
            report_problem($sformatf("Master %0d got a response with nothing outstanding", i));
          end else begin
            if (m_r_rdata_i[i] !== exp_rdata[i]) begin
              report_value($sformatf("m_r_rdata_o[%0d]", i), m_r_rdata_i[i], exp_rdata[i]);
            end
            pending[i]   = 1'b0;
            forwarded[i] = 1'b0;
          end
        end
      end

      for (int s = 0; s < NB_SLAVES; s++) begin
        if (s_req_i[s] && s_gnt_i[s]) begin
          if (!$onehot(s_id_i[s])) begin
            report_problem($sformatf("Slave %0d transfer carries ID %h, which is not one-hot",
                                     s, s_id_i[s]));
          end else begin
            m = 0;
            for (int i = 0; i < NB_MASTERS; i++) begin
              if (s_id_i[s][i]) m = i;
            end
            if (!pending[m] || forwarded[m]) begin
              report_problem($sformatf("Slave %0d got a request master %0d never issued", s, m));
            end else begin
              if (exp_target[m] != s) begin
                report_problem($sformatf("Master %0d request went to slave %0d, not slave %0d",
                                         m, s, exp_target[m]));
              end
              if (s_add_i[s] !== exp_add[m]) report_value("s_add_o", s_add_i[s], exp_add[m]);
              if (s_wen_i[s] !== exp_wen[m]) report_value("s_wen_o", 32'(s_wen_i[s]),
                                                          32'(exp_wen[m]));
              if (s_wdata_i[s] !== exp_wdata[m]) report_value("s_wdata_o", s_wdata_i[s],
                                                              exp_wdata[m]);
              if (s_be_i[s] !== exp_be[m]) report_value("s_be_o", 32'(s_be_i[s]), 32'(exp_be[m]));
              if (waits[m] > NB_MASTERS - 1) begin
                report_problem($sformatf("Master %0d waited %0d transfers on slave %0d",
                                         m, waits[m], s));
              end
              key = int'(exp_add[m][9:2]);
              exp_rdata[m] = '0;
              if (exp_wen[m]) begin
                exp_rdata[m] = mirror[s][key];
              end else begin
                for (int b = 0; b < BE_WIDTH; b++) begin
                  if (exp_be[m][b]) mirror[s][key][8*b +: 8] = exp_wdata[m][8*b +: 8];
                end
              end
              forwarded[m] = 1'b1;
            end
            // Everyone still queued on this slave was passed over once more
            for (int i = 0; i < NB_MASTERS; i++) begin
              if (pending[i] && !forwarded[i] && exp_target[i] == s) waits[i] = waits[i] + 1;
            end
          end
        end
      end

      for (int i = 0; i < NB_MASTERS; i++) begin
        if (m_req_i[i] && m_gnt_i[i]) begin
          pending[i]    = 1'b1;
          forwarded[i]  = 1'b0;
          exp_add[i]    = m_add_i[i];
          exp_wdata[i]  = m_wdata_i[i];
          exp_wen[i]    = m_wen_i[i];
          exp_be[i]     = m_be_i[i];
          exp_target[i] = decode_target(m_add_i[i]);
          waits[i]      = 0;
        end
      end
    end
  end

endmodule

`default_nettype wire

// ==== logic/cluster_periph_xbar.sv ====
// Peripheral crossbar, NB_MASTERS requesters to NB_SLAVES targets.
// Each master may keep only one transaction outstanding; responses are
// routed by the one-hot ID the slave echoes back.
// The last slave is the external target.
`timescale 1ns/1ps
`default_nettype none

module cluster_periph_xbar #(
  parameter int NB_MASTERS = 4,
  parameter int NB_SLAVES  = 4
) (
  input  wire logic                                     clk_i,
  input  wire logic                                     reset_i,
  input  wire logic [NB_MASTERS-1:0]                    m_req_i,
  input  wire periph_xbar_pkg::addr_t [NB_MASTERS-1:0]  m_add_i,
  input  wire logic [NB_MASTERS-1:0]                    m_wen_i,
  input  wire periph_xbar_pkg::data_t [NB_MASTERS-1:0]  m_wdata_i,
  input  wire periph_xbar_pkg::be_t [NB_MASTERS-1:0]    m_be_i,
  output logic [NB_MASTERS-1:0]                         m_gnt_o,
  output logic [NB_MASTERS-1:0]                         m_r_valid_o,
  output periph_xbar_pkg::data_t [NB_MASTERS-1:0]       m_r_rdata_o,
  output logic [NB_SLAVES-1:0]                          s_req_o,
  output periph_xbar_pkg::addr_t [NB_SLAVES-1:0]        s_add_o,
  output logic [NB_SLAVES-1:0]                          s_wen_o,
  output periph_xbar_pkg::data_t [NB_SLAVES-1:0]        s_wdata_o,
  output periph_xbar_pkg::be_t [NB_SLAVES-1:0]          s_be_o,
  output logic [NB_SLAVES-1:0][NB_MASTERS-1:0]          s_id_o,
  input  wire logic [NB_SLAVES-1:0]                     s_gnt_i,
  input  wire logic [NB_SLAVES-1:0]                     s_r_valid_i,
  input  wire periph_xbar_pkg::data_t [NB_SLAVES-1:0]   s_r_rdata_i,
  input  wire logic [NB_SLAVES-1:0][NB_MASTERS-1:0]     s_r_id_i
);

  import periph_xbar_pkg::*;

  localparam int IDX_WIDTH = $clog2(NB_SLAVES);

  logic [NB_MASTERS-1:0]                slot_valid;
  logic [NB_MASTERS-1:0][IDX_WIDTH-1:0] slot_target;
  addr_t [NB_MASTERS-1:0]               slot_add;
  logic [NB_MASTERS-1:0]                slot_wen;
  data_t [NB_MASTERS-1:0]               slot_wdata;
  be_t [NB_MASTERS-1:0]                 slot_be;
  logic [NB_MASTERS-1:0]                slot_gnt;
  logic [NB_SLAVES-1:0][NB_MASTERS-1:0] arb_gnt;

  for (genvar m = 0; m < NB_MASTERS; m++) begin : gen_req_stage
    periph_req_stage #(
      .NB_SLAVES (NB_SLAVES)
    ) periph_req_stage_inst (
      .clk_i         (clk_i),
      .reset_i       (reset_i),
      .req_i         (m_req_i[m]),
      .add_i         (m_add_i[m]),
      .wen_i         (m_wen_i[m]),
      .wdata_i       (m_wdata_i[m]),
      .be_i          (m_be_i[m]),
      .slot_gnt_i    (slot_gnt[m]),
      .gnt_o         (m_gnt_o[m]),
      .slot_valid_o  (slot_valid[m]),
      .slot_add_o    (slot_add[m]),
      .slot_wen_o    (slot_wen[m]),
      .slot_wdata_o  (slot_wdata[m]),
      .slot_be_o     (slot_be[m]),
      .slot_target_o (slot_target[m])
    );
  end

  // A slot targets one slave, so at most one arbiter grants it
  always_comb begin
    slot_gnt = '0;
    for (int s = 0; s < NB_SLAVES; s++) begin
      slot_gnt = slot_gnt | arb_gnt[s];
    end
  end

  for (genvar s = 0; s < NB_SLAVES; s++) begin : gen_arb
    periph_rr_arbiter #(
      .NB_MASTERS (NB_MASTERS),
      .NB_SLAVES  (NB_SLAVES),
      .SLAVE_IDX  (s)
    ) periph_rr_arbiter_inst (
      .clk_i         (clk_i),
      .reset_i       (reset_i),
      .slot_valid_i  (slot_valid),
      .slot_target_i (slot_target),
      .slot_add_i    (slot_add),
      .slot_wen_i    (slot_wen),
      .slot_wdata_i  (slot_wdata),
      .slot_be_i     (slot_be),
      .s_gnt_i       (s_gnt_i[s]),
      .slot_gnt_o    (arb_gnt[s]),
      .s_req_o       (s_req_o[s]),
      .s_add_o       (s_add_o[s]),
      .s_wen_o       (s_wen_o[s]),
      .s_wdata_o     (s_wdata_o[s]),
      .s_be_o        (s_be_o[s]),
      .s_id_o        (s_id_o[s])
    );
  end

  periph_resp_router #(
    .NB_MASTERS (NB_MASTERS),
    .NB_SLAVES  (NB_SLAVES)
  ) periph_resp_router_inst (
    .s_r_valid_i (s_r_valid_i),
    .s_r_rdata_i (s_r_rdata_i),
    .s_r_id_i    (s_r_id_i),
    .m_r_valid_o (m_r_valid_o),
    .m_r_rdata_o (m_r_rdata_o)
  );

endmodule

`default_nettype wire

// ==== periph_xbar/periph_resp_router.sv ====
// Steers slave responses back to masters by one-hot ID.
// Purely combinational. At most one slave answers a given master in a
// cycle, so the one-hot to binary conversion below is exact.
`timescale 1ns/1ps
`default_nettype none

module periph_resp_router #(
  parameter int NB_MASTERS = 4,
  parameter int NB_SLAVES  = 4,
  localparam int IDX_WIDTH = $clog2(NB_SLAVES)
) (
  input  wire logic [NB_SLAVES-1:0]                    s_r_valid_i,
  input  wire periph_xbar_pkg::data_t [NB_SLAVES-1:0]  s_r_rdata_i,
  input  wire logic [NB_SLAVES-1:0][NB_MASTERS-1:0]    s_r_id_i,
  output logic [NB_MASTERS-1:0]                        m_r_valid_o,
  output periph_xbar_pkg::data_t [NB_MASTERS-1:0]      m_r_rdata_o
);

  import periph_xbar_pkg::*;

  for (genvar m = 0; m < NB_MASTERS; m++) begin : gen_master
    logic [NB_SLAVES-1:0] hit;
    logic [IDX_WIDTH-1:0] sel;
    data_t                rdata;

    for (genvar s = 0; s < NB_SLAVES; s++) begin : gen_hit
      assign hit[s] = s_r_valid_i[s] && (s_r_id_i[s] == (NB_MASTERS'(1) << m));
    end

    always_comb begin
      sel = '0;
      for (int s = 0; s < NB_SLAVES; s++) begin
        if (hit[s]) begin
          sel = sel | IDX_WIDTH'(s);
        end
      end
    end

    assign rdata          = s_r_rdata_i[sel];
    assign m_r_rdata_o[m] = rdata;
    assign m_r_valid_o[m] = |hit;
  end

endmodule

`default_nettype wire

// ==== periph_xbar/periph_rr_arbiter.sv ====
// Round-robin arbiter in front of one slave.
// Grant is combinational on s_gnt_i. The pointer moves past the winner
// only on a completed slave transfer.
`timescale 1ns/1ps
`default_nettype none

module periph_rr_arbiter #(
  parameter int NB_MASTERS = 4,
  parameter int NB_SLAVES  = 4,
  parameter int SLAVE_IDX  = 0,
  localparam int IDX_WIDTH = $clog2(NB_SLAVES)
) (
  input  wire logic                                      clk_i,
  input  wire logic                                      reset_i,
  input  wire logic [NB_MASTERS-1:0]                     slot_valid_i,
  input  wire logic [NB_MASTERS-1:0][IDX_WIDTH-1:0]      slot_target_i,
  input  wire periph_xbar_pkg::addr_t [NB_MASTERS-1:0]   slot_add_i,
  input  wire logic [NB_MASTERS-1:0]                     slot_wen_i,
  input  wire periph_xbar_pkg::data_t [NB_MASTERS-1:0]   slot_wdata_i,
  input  wire periph_xbar_pkg::be_t [NB_MASTERS-1:0]     slot_be_i,
  input  wire logic                                      s_gnt_i,
  output logic [NB_MASTERS-1:0]                          slot_gnt_o,
  output logic                                           s_req_o,
  output periph_xbar_pkg::addr_t                         s_add_o,
  output logic                                           s_wen_o,
  output periph_xbar_pkg::data_t                         s_wdata_o,
  output periph_xbar_pkg::be_t                           s_be_o,
  output logic [NB_MASTERS-1:0]                          s_id_o
);

  import periph_xbar_pkg::*;

  localparam int MIDX = (NB_MASTERS > 1) ? $clog2(NB_MASTERS) : 1;

  typedef struct packed {
    addr_t                 addr;
    data_t                 data;
    logic [NB_MASTERS-1:0] id;
    logic                  we_n;
    be_t                   be;
  } req_t;

  req_t [NB_MASTERS-1:0] reqs;
  req_t                  win_req;
  logic [NB_MASTERS-1:0] match;
  logic [MIDX-1:0]       ptr_q;
  logic [MIDX-1:0]       winner;
  logic                  found;

  for (genvar m = 0; m < NB_MASTERS; m++) begin : gen_req
    assign match[m]     = slot_valid_i[m] && (slot_target_i[m] == IDX_WIDTH'(SLAVE_IDX));
    assign reqs[m].addr = slot_add_i[m];
    assign reqs[m].data = slot_wdata_i[m];
    assign reqs[m].id   = NB_MASTERS'(1) << m;
    assign reqs[m].we_n = slot_wen_i[m];
    assign reqs[m].be   = slot_be_i[m];
    assign slot_gnt_o[m] = found && s_gnt_i && (winner == MIDX'(m));
  end

  // First matching master at or after the pointer
  always_comb begin
    int unsigned cand;
    found  = 1'b0;
    winner = '0;
    cand   = 0;
    for (int unsigned i = 0; i < NB_MASTERS; i++) begin
      cand = (int'(ptr_q) + i) % NB_MASTERS;
      if (!found && match[cand]) begin
        found  = 1'b1;
        winner = MIDX'(cand);
      end
    end
  end

  assign win_req   = reqs[winner];
  assign s_req_o   = found;
  assign s_add_o   = win_req.addr;
  assign s_wen_o   = win_req.we_n;
  assign s_wdata_o = win_req.data;
  assign s_be_o    = win_req.be;
  assign s_id_o    = win_req.id;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      ptr_q <= '0;
    end else if (found && s_gnt_i) begin
      ptr_q <= (winner == MIDX'(NB_MASTERS - 1)) ? '0 : winner + 1'b1;
    end
  end

endmodule

`default_nettype wire

// ==== periph_xbar/periph_req_stage.sv ====
// One-entry request slot for a single master.
// Target is decoded once, when the slot loads. Addresses outside the
// cluster peripheral window go to the last slave.
// NB_SLAVES must be a power of two and at least 2.
`timescale 1ns/1ps
`default_nettype none

module periph_req_stage #(
  parameter int NB_SLAVES = 4,
  localparam int IDX_WIDTH = $clog2(NB_SLAVES)
) (
  input  wire logic                   clk_i,
  input  wire logic                   reset_i,
  input  wire logic                   req_i,
  input  wire periph_xbar_pkg::addr_t add_i,
  input  wire logic                   wen_i,
  input  wire periph_xbar_pkg::data_t wdata_i,
  input  wire periph_xbar_pkg::be_t   be_i,
  input  wire logic                   slot_gnt_i,
  output logic                        gnt_o,
  output logic                        slot_valid_o,
  output periph_xbar_pkg::addr_t      slot_add_o,
  output logic                        slot_wen_o,
  output periph_xbar_pkg::data_t      slot_wdata_o,
  output periph_xbar_pkg::be_t        slot_be_o,
  output logic [IDX_WIDTH-1:0]        slot_target_o
);

  import periph_xbar_pkg::*;

  localparam logic [IDX_WIDTH-1:0] EXT_IDX = IDX_WIDTH'(NB_SLAVES - 1);

  typedef struct packed {
    addr_t                addr;
    data_t                data;
    logic                 we_n;
    be_t                  be;
    logic [IDX_WIDTH-1:0] target;
  } slot_t;

  slot_t                slot_q;
  logic                 valid_q;
  logic                 load;
  logic [IDX_WIDTH-1:0] target_dec;

  always_comb begin
    target_dec = EXT_IDX;
    if (add_i[31:24] == CLUSTER_BASE &&
        add_i[23:20] >= PERIPH_WIN_LO && add_i[23:20] <= PERIPH_WIN_HI) begin
      target_dec = add_i[PE_ROUTING_LSB +: IDX_WIDTH];
    end
  end

  // Accept while empty, or while the held request leaves this cycle
  assign gnt_o = !valid_q || slot_gnt_i;
  assign load  = req_i && gnt_o;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      valid_q <= 1'b0;
    end else if (load) begin
      valid_q <= 1'b1;
    end else if (slot_gnt_i) begin
      valid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (load) begin
      slot_q.addr   <= add_i;
      slot_q.data   <= wdata_i;
      slot_q.we_n   <= wen_i;
      slot_q.be     <= be_i;
      slot_q.target <= target_dec;
    end
  end

  assign slot_valid_o  = valid_q;
  assign slot_add_o    = slot_q.addr;
  assign slot_wen_o    = slot_q.we_n;
  assign slot_wdata_o  = slot_q.data;
  assign slot_be_o     = slot_q.be;
  assign slot_target_o = slot_q.target;

endmodule

`default_nettype wire

// ==== common/periph_xbar_pkg.sv ====
// Bus types and address map shared by the peripheral crossbar.
// The request struct depends on the master count, so each module builds
// its own from the field types below.
`default_nettype none

package periph_xbar_pkg;

  localparam int ADDR_WIDTH = 32;
  localparam int DATA_WIDTH = 32;
  localparam int BE_WIDTH   = DATA_WIDTH / 8;

  typedef logic [ADDR_WIDTH-1:0] addr_t;
  typedef logic [DATA_WIDTH-1:0] data_t;
  typedef logic [BE_WIDTH-1:0]   be_t;

  // Cluster address space is selected by the top byte
  localparam logic [7:0] CLUSTER_BASE = 8'h10;

  // Peripheral window on address nibble [23:20], both ends inclusive
  localparam logic [3:0] PERIPH_WIN_LO = 4'h2;
  localparam logic [3:0] PERIPH_WIN_HI = 4'h3;

  // Target index is taken from the address starting at this bit
  localparam int PE_ROUTING_LSB = 16;

endpackage

`default_nettype wire
